/* hw/alert_pkg.sv */
////////////////////////////////////////
// Shared sizes, register map offsets and types of the alert handler
// Imported by every RTL module and by the testbench
////////////////////////////////////////
`default_nettype none

package alert_pkg;

  // Sizes
  localparam int N_ALERTS  = 8;
  localparam int N_CLASSES = 2;
  localparam int N_ESC_SEV = 2;
  localparam int CNT_W     = 16;

  ////////////////////////////////////////
  // Register offsets, byte addresses
  ////////////////////////////////////////
  localparam logic [7:0] INTR_STATE_OFS  = 8'h00;
  localparam logic [7:0] INTR_ENABLE_OFS = 8'h04;
  localparam logic [7:0] ALERT_EN_OFS    = 8'h08;
  localparam logic [7:0] ALERT_CLASS_OFS = 8'h0C;
  localparam logic [7:0] ALERT_CAUSE_OFS = 8'h10;
  localparam logic [7:0] CLASS_STATE_OFS = 8'h14;
  localparam logic [7:0] CLASS_BASE_OFS  = 8'h20;
  localparam logic [7:0] CLASS_STRIDE    = 8'h20;

  // Within one class block
  localparam logic [7:0] CTRL_OFS      = 8'h00;
  localparam logic [7:0] THRESH_OFS    = 8'h04;
  localparam logic [7:0] TIMEOUT_OFS   = 8'h08;
  localparam logic [7:0] PHASE_OFS     = 8'h0C;
  localparam logic [7:0] ACCUM_CNT_OFS = 8'h10;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_PHASE0   = 3'd1,
    ST_PHASE1   = 3'd2,
    ST_TERMINAL = 3'd3
  } esc_state_e;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic             en;
    logic [CNT_W-1:0] thresh;
    logic [CNT_W-1:0] timeout_cyc;
    logic [CNT_W-1:0] phase_cyc;
  } class_cfg_t;

  typedef struct packed {
    logic [CNT_W-1:0] accu_cnt;
    esc_state_e       esc_state;
  } class_status_t;

endpackage

`default_nettype wire

/* hw/alert_reg_apb.sv */
////////////////////////////////////////
// APB register block of the alert handler
// Holds configuration, cause and interrupt bits, issues class clears
// and returns class status on reads. No wait states
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alert_reg_apb
  import alert_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  input  wire apb_req_t                      apb_req_i,
  output apb_rsp_t                           apb_rsp_o,
  input  wire logic [N_ALERTS-1:0]           cause_set_i,
  input  wire logic [N_CLASSES-1:0]          class_trig_i,
  input  wire class_status_t [N_CLASSES-1:0] status_i,
  output logic [N_ALERTS-1:0]                alert_en_o,
  output logic [N_ALERTS-1:0]                alert_class_o,
  output class_cfg_t [N_CLASSES-1:0]         cfg_o,
  output logic [N_CLASSES-1:0]               clr_o,
  output logic [N_CLASSES-1:0]               irq_o
);

  logic                       access;
  logic                       wr_en;
  logic                       mapped;
  logic [31:0]                rdata;
  logic                       sel_intr_state;
  logic                       sel_intr_enable;
  logic                       sel_alert_en;
  logic                       sel_alert_class;
  logic                       sel_alert_cause;
  logic [N_CLASSES-1:0]       sel_ctrl;
  logic [N_CLASSES-1:0]       sel_thresh;
  logic [N_CLASSES-1:0]       sel_timeout;
  logic [N_CLASSES-1:0]       sel_phase;
  logic [7:0]                 cls_rel;
  logic [7:0]                 cls_idx;
  logic [7:0]                 cls_ofs;
  logic                       cls_hit;
  logic [N_CLASSES-1:0]       intr_state_q;
  logic [N_CLASSES-1:0]       intr_enable_q;
  logic [N_CLASSES-1:0]       intr_w1c;
  logic [N_ALERTS-1:0]        alert_en_q;
  logic [N_ALERTS-1:0]        alert_class_q;
  logic [N_ALERTS-1:0]        alert_cause_q;
  logic [N_ALERTS-1:0]        cause_w1c;
  class_cfg_t [N_CLASSES-1:0] cfg_q;
  logic [N_CLASSES-1:0]       clr_q;

  assign access = apb_req_i.psel && apb_req_i.penable;
  assign wr_en  = access && apb_req_i.pwrite;

  // Class block position of the address
  assign cls_rel = apb_req_i.paddr - CLASS_BASE_OFS;
  assign cls_idx = cls_rel / CLASS_STRIDE;
  assign cls_ofs = cls_rel % CLASS_STRIDE;
  assign cls_hit = (apb_req_i.paddr >= CLASS_BASE_OFS) && (cls_idx < 8'(N_CLASSES));

  ////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////
  always_comb begin
    mapped          = 1'b1;
    rdata           = '0;
    sel_intr_state  = 1'b0;
    sel_intr_enable = 1'b0;
    sel_alert_en    = 1'b0;
    sel_alert_class = 1'b0;
    sel_alert_cause = 1'b0;
    sel_ctrl        = '0;
    sel_thresh      = '0;
    sel_timeout     = '0;
    sel_phase       = '0;
    case (apb_req_i.paddr)
      INTR_STATE_OFS: begin
        sel_intr_state = 1'b1;
        rdata[N_CLASSES-1:0] = intr_state_q;
      end
      INTR_ENABLE_OFS: begin
        sel_intr_enable = 1'b1;
        rdata[N_CLASSES-1:0] = intr_enable_q;
      end
      ALERT_EN_OFS: begin
        sel_alert_en = 1'b1;
        rdata[N_ALERTS-1:0] = alert_en_q;
      end
      ALERT_CLASS_OFS: begin
        sel_alert_class = 1'b1;
        rdata[N_ALERTS-1:0] = alert_class_q;
      end
      ALERT_CAUSE_OFS: begin
        sel_alert_cause = 1'b1;
        rdata[N_ALERTS-1:0] = alert_cause_q;
      end
      CLASS_STATE_OFS: begin
        for (int c = 0; c < N_CLASSES; c++) begin
          rdata[3*c +: 3] = status_i[c].esc_state;
        end
      end
      default: begin
        mapped = 1'b0;
        for (int c = 0; c < N_CLASSES; c++) begin
          if (cls_hit && cls_idx == 8'(c)) begin
            mapped = 1'b1;
            case (cls_ofs)
              CTRL_OFS: begin
                sel_ctrl[c] = 1'b1;
                rdata[0] = cfg_q[c].en;
              end
              THRESH_OFS: begin
                sel_thresh[c] = 1'b1;
                rdata[CNT_W-1:0] = cfg_q[c].thresh;
              end
              TIMEOUT_OFS: begin
                sel_timeout[c] = 1'b1;
                rdata[CNT_W-1:0] = cfg_q[c].timeout_cyc;
              end
              PHASE_OFS: begin
                sel_phase[c] = 1'b1;
                rdata[CNT_W-1:0] = cfg_q[c].phase_cyc;
              end
              ACCUM_CNT_OFS: rdata[CNT_W-1:0] = status_i[c].accu_cnt;
              default:       mapped = 1'b0;
            endcase
          end
        end
      end
    endcase
  end

  // Write-1-to-clear masks
  assign intr_w1c  = (wr_en && sel_intr_state) ? apb_req_i.pwdata[N_CLASSES-1:0] : '0;
  assign cause_w1c = (wr_en && sel_alert_cause) ? apb_req_i.pwdata[N_ALERTS-1:0] : '0;

  ////////////////////////////////////////
  // Register state
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      intr_state_q  <= '0;
      intr_enable_q <= '0;
      alert_en_q    <= '0;
      alert_class_q <= '0;
      alert_cause_q <= '0;
      cfg_q         <= '0;
      clr_q         <= '0;
    end else begin
      // Hardware set beats a software clear
      intr_state_q  <= (intr_state_q & ~intr_w1c) | class_trig_i;
      alert_cause_q <= (alert_cause_q & ~cause_w1c) | cause_set_i;
      if (wr_en && sel_intr_enable) begin
        intr_enable_q <= apb_req_i.pwdata[N_CLASSES-1:0];
      end
      if (wr_en && sel_alert_en) begin
        alert_en_q <= apb_req_i.pwdata[N_ALERTS-1:0];
      end
      if (wr_en && sel_alert_class) begin
        alert_class_q <= apb_req_i.pwdata[N_ALERTS-1:0];
      end
      for (int c = 0; c < N_CLASSES; c++) begin
        clr_q[c] <= wr_en && sel_ctrl[c] && apb_req_i.pwdata[1];
        if (wr_en && sel_ctrl[c]) begin
          cfg_q[c].en <= apb_req_i.pwdata[0];
        end
        if (wr_en && sel_thresh[c]) begin
          cfg_q[c].thresh <= apb_req_i.pwdata[CNT_W-1:0];
        end
        if (wr_en && sel_timeout[c]) begin
          cfg_q[c].timeout_cyc <= apb_req_i.pwdata[CNT_W-1:0];
        end
        if (wr_en && sel_phase[c]) begin
          cfg_q[c].phase_cyc <= apb_req_i.pwdata[CNT_W-1:0];
        end
      end
    end
  end

  assign alert_en_o    = alert_en_q;
  assign alert_class_o = alert_class_q;
  assign cfg_o         = cfg_q;
  assign clr_o         = clr_q;
  assign irq_o         = intr_state_q & intr_enable_q;

  // Response, only meaningful in the access phase
  always_comb begin
    apb_rsp_o.pready  = access;
    apb_rsp_o.pslverr = access && !mapped;
    apb_rsp_o.prdata  = access ? rdata : '0;
  end

endmodule

`default_nettype wire

/* hw/alert_classify.sv */
////////////////////////////////////////
// Alert masking and class mapping
// Purely combinational, sits between the alert pins and the class logic
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alert_classify
  import alert_pkg::*;
(
  input  wire logic [N_ALERTS-1:0] alert_i,
  input  wire logic [N_ALERTS-1:0] alert_en_i,
  input  wire logic [N_ALERTS-1:0] alert_class_i,
  output logic [N_ALERTS-1:0]      cause_set_o,
  output logic [N_CLASSES-1:0]     class_trig_o
);

  logic [N_ALERTS-1:0] alert_act;

  // Masked alerts survive as causes
  assign alert_act   = alert_i & alert_en_i;
  assign cause_set_o = alert_act;

  // Gather each surviving alert into its class trigger
  always_comb begin
    class_trig_o = '0;
    for (int k = 0; k < N_ALERTS; k++) begin
      if (alert_act[k]) begin
        class_trig_o[alert_class_i[k]] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/alert_accu.sv */
////////////////////////////////////////
// Per-class alert accumulator
// Counts class triggers and fires once the count reaches the threshold
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alert_accu
  import alert_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             en_i,
  input  wire logic             clr_i,
  input  wire logic             class_trig_i,
  input  wire logic             idle_i,
  input  wire logic [CNT_W-1:0] thresh_i,
  output logic [CNT_W-1:0]      accu_cnt_o,
  output logic                  accu_trig_o
);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W:0]   cnt_next;

  // One bit wider so the compare still works at saturation
  assign cnt_next = {1'b0, cnt_q} + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i) begin
      cnt_q <= '0;
    end else if (en_i && class_trig_i && !(&cnt_q)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign accu_cnt_o  = cnt_q;
  assign accu_trig_o = en_i && class_trig_i && idle_i && (cnt_next >= {1'b0, thresh_i});

endmodule

`default_nettype wire

/* hw/alert_irq_timeout.sv */
////////////////////////////////////////
// Per-class interrupt timeout
// Counts cycles of an unserviced interrupt while the class is idle,
// a zero timeout turns the trigger off
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alert_irq_timeout
  import alert_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             en_i,
  input  wire logic             clr_i,
  input  wire logic             irq_i,
  input  wire logic             idle_i,
  input  wire logic [CNT_W-1:0] timeout_cyc_i,
  output logic                  timeout_trig_o
);

  logic [CNT_W-1:0] cnt_q;
  logic             cnt_en;

  assign cnt_en = en_i && irq_i && idle_i;

  // Restart whenever the interrupt is serviced
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i || !irq_i) begin
      cnt_q <= '0;
    end else if (cnt_en && !(&cnt_q)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign timeout_trig_o = cnt_en && (timeout_cyc_i != '0) && (cnt_q == timeout_cyc_i);

endmodule

`default_nettype wire

/* hw/alert_esc_fsm.sv */
////////////////////////////////////////
// Per-class escalation phase FSM
// Two timed phases after a trigger, then a terminal state held until
// software clears the class
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alert_esc_fsm
  import alert_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             en_i,
  input  wire logic             clr_i,
  input  wire logic             accu_trig_i,
  input  wire logic             timeout_trig_i,
  input  wire logic [CNT_W-1:0] phase_cyc_i,
  output esc_state_e            esc_state_o,
  output logic                  idle_o,
  output logic [N_ESC_SEV-1:0]  esc_req_o
);

  esc_state_e       state_q;
  esc_state_e       state_d;
  logic [CNT_W-1:0] phase_cnt_q;
  logic             in_phase;
  logic             phase_last;

  assign in_phase = (state_q == ST_PHASE0) || (state_q == ST_PHASE1);

  // Last cycle of a phase, a zero length still gives one cycle
  assign phase_last = ({1'b0, phase_cnt_q} + 1'b1) >= {1'b0, phase_cyc_i};

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (en_i && (accu_trig_i || timeout_trig_i)) begin
          state_d = ST_PHASE0;
        end
      end
      ST_PHASE0: begin
        if (phase_last) begin
          state_d = ST_PHASE1;
        end
      end
      ST_PHASE1: begin
        if (phase_last) begin
          state_d = ST_TERMINAL;
        end
      end
      ST_TERMINAL: state_d = ST_TERMINAL;
      default:     state_d = ST_IDLE;
    endcase
    if (clr_i) begin
      state_d = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Phase cycle counter, restarts on every phase change
  always_ff @(posedge clk_i) begin
    if (rst_i || clr_i || !in_phase || phase_last) begin
      phase_cnt_q <= '0;
    end else begin
      phase_cnt_q <= phase_cnt_q + 1'b1;
    end
  end

  assign esc_state_o = state_q;
  assign idle_o      = (state_q == ST_IDLE);

  // Phase k drives severity k, terminal keeps the last one up
  always_comb begin
    esc_req_o    = '0;
    esc_req_o[0] = (state_q == ST_PHASE0);
    esc_req_o[1] = (state_q == ST_PHASE1) || (state_q == ST_TERMINAL);
  end

endmodule

`default_nettype wire

/* hw/alert_handler_top.sv */
////////////////////////////////////////
// Alert handler top level
// APB register block, alert classifier and one accumulator, timeout
// and escalation FSM per class
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alert_handler_top
  import alert_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire apb_req_t            apb_req_i,
  output apb_rsp_t                 apb_rsp_o,
  input  wire logic [N_ALERTS-1:0] alert_i,
  output logic [N_CLASSES-1:0]     intr_o,
  output logic [N_ESC_SEV-1:0]     esc_o
);

  logic [N_ALERTS-1:0]                alert_en;
  logic [N_ALERTS-1:0]                alert_class;
  logic [N_ALERTS-1:0]                cause_set;
  logic [N_CLASSES-1:0]               class_trig;
  logic [N_CLASSES-1:0]               clr;
  logic [N_CLASSES-1:0]               irq;
  class_cfg_t [N_CLASSES-1:0]         cfg;
  wire class_status_t [N_CLASSES-1:0] status;
  wire [N_CLASSES-1:0][N_ESC_SEV-1:0] esc_req;

  assign intr_o = irq;

  ////////////////////////////////////////
  // Registers and classification
  ////////////////////////////////////////
  alert_reg_apb u_reg (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .apb_req_i     ( apb_req_i   ),
    .apb_rsp_o     ( apb_rsp_o   ),
    .cause_set_i   ( cause_set   ),
    .class_trig_i  ( class_trig  ),
    .status_i      ( status      ),
    .alert_en_o    ( alert_en    ),
    .alert_class_o ( alert_class ),
    .cfg_o         ( cfg         ),
    .clr_o         ( clr         ),
    .irq_o         ( irq         )
  );

  alert_classify u_classify (
    .alert_i       ( alert_i     ),
    .alert_en_i    ( alert_en    ),
    .alert_class_i ( alert_class ),
    .cause_set_o   ( cause_set   ),
    .class_trig_o  ( class_trig  )
  );

  ////////////////////////////////////////
  // Per-class escalation
  ////////////////////////////////////////
  for (genvar c = 0; c < N_CLASSES; c++) begin : gen_class
    logic idle;
    logic accu_trig;
    logic timeout_trig;

    alert_accu u_accu (
      .clk_i        ( clk_i              ),
      .rst_i        ( rst_i              ),
      .en_i         ( cfg[c].en          ),
      .clr_i        ( clr[c]             ),
      .class_trig_i ( class_trig[c]      ),
      .idle_i       ( idle               ),
      .thresh_i     ( cfg[c].thresh      ),
      .accu_cnt_o   ( status[c].accu_cnt ),
      .accu_trig_o  ( accu_trig          )
    );

    alert_irq_timeout u_timeout (
      .clk_i          ( clk_i              ),
      .rst_i          ( rst_i              ),
      .en_i           ( cfg[c].en          ),
      .clr_i          ( clr[c]             ),
      .irq_i          ( irq[c]             ),
      .idle_i         ( idle               ),
      .timeout_cyc_i  ( cfg[c].timeout_cyc ),
      .timeout_trig_o ( timeout_trig       )
    );

    alert_esc_fsm u_esc_fsm (
      .clk_i          ( clk_i               ),
      .rst_i          ( rst_i               ),
      .en_i           ( cfg[c].en           ),
      .clr_i          ( clr[c]              ),
      .accu_trig_i    ( accu_trig           ),
      .timeout_trig_i ( timeout_trig        ),
      .phase_cyc_i    ( cfg[c].phase_cyc    ),
      .esc_state_o    ( status[c].esc_state ),
      .idle_o         ( idle                ),
      .esc_req_o      ( esc_req[c]          )
    );
  end

  // Any class can drive any severity
  always_comb begin
    esc_o = '0;
    for (int c = 0; c < N_CLASSES; c++) begin
      esc_o = esc_o | esc_req[c];
    end
  end

endmodule

`default_nettype wire

/* sim/tb_alert_handler.sv */
////////////////////////////////////////
// Directed testbench for the alert handler top level
// Drives APB and alert pulses, checks registers, interrupts, escalation
// and clears against the register map
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_alert_handler
  import alert_pkg::*;
;

  localparam int          CLK_PERIOD = 40;
  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] SEED       = 32'h279e_7e84;

  logic                 clk;
  logic                 rst;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic [N_ALERTS-1:0]  alert;
  logic [N_CLASSES-1:0] intr;
  logic [N_ESC_SEV-1:0] esc;
  logic                 last_slverr;
  int                   n_checks;
  int                   n_errors;
  int                   n_tests;
  int                   n_failed_tests;
  int                   err_base;

  alert_handler_top UUT (
    .clk_i     ( clk     ),
    .rst_i     ( rst     ),
    .apb_req_i ( apb_req ),
    .apb_rsp_o ( apb_rsp ),
    .alert_i   ( alert   ),
    .intr_o    ( intr    ),
    .esc_o     ( esc     )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Compare tasks and bookkeeping
  ////////////////////////////////////////
  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_esc(input string name, input logic [N_ESC_SEV-1:0] got,
                           input logic [N_ESC_SEV-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input esc_state_e got, input esc_state_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    n_errors++;
    $display("Error: %s", what);
  endtask

  task automatic start_test();
    err_base = n_errors;
    n_tests++;
  endtask

  task automatic finish_test(input string name);
    if (n_errors == err_base) begin
      $display("Test %s passed", name);
    end else begin
      n_failed_tests++;
      $display("Test %s failed with %0d errors", name, n_errors - err_base);
    end
  endtask

  function automatic logic [7:0] class_addr(input int c, input logic [7:0] ofs);
    return CLASS_BASE_OFS + 8'(c) * CLASS_STRIDE + ofs;
  endfunction

  ////////////////////////////////////////
  // Bus and alert drivers
  ////////////////////////////////////////
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!apb_rsp.pready && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!apb_rsp.pready) begin
      report_error("Timeout waiting for APB pready");
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    apb_req.paddr   <= addr;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    wait_ready();
    last_slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    apb_req.paddr   <= addr;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    wait_ready();
    data        = apb_rsp.prdata;
    last_slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic pulse_alert(input logic [N_ALERTS-1:0] mask);
    @(posedge clk);
    alert <= mask;
    @(posedge clk);
    alert <= '0;
  endtask

  // Returns at the negedge where all requested bits are up
  task automatic wait_esc(input logic [N_ESC_SEV-1:0] bits);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((esc & bits) != bits && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if ((esc & bits) != bits) begin
      report_error($sformatf("Timeout waiting for esc_o bits 0x%0h", bits));
    end
  endtask

  task automatic wait_state(input int c, input esc_state_e st);
    logic [31:0] data;
    int          polls;
    polls = 0;
    apb_read(CLASS_STATE_OFS, data);
    while (esc_state_e'(data[3*c +: 3]) != st && polls < WAIT_LIMIT) begin
      apb_read(CLASS_STATE_OFS, data);
      polls++;
    end
    if (esc_state_e'(data[3*c +: 3]) != st) begin
      report_error($sformatf("Timeout waiting for class %0d to reach %s", c, st.name()));
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_registers();
    logic [31:0] en_val;
    logic [31:0] cls_val;
    logic [31:0] data;
    logic [31:0] exp_cfg [N_CLASSES][3];
    logic [7:0]  cfg_ofs [3];
    start_test();
    cfg_ofs[0] = THRESH_OFS;
    cfg_ofs[1] = TIMEOUT_OFS;
    cfg_ofs[2] = PHASE_OFS;
    en_val  = $urandom & 32'hFF;
    cls_val = $urandom & 32'hFF;
    apb_write(ALERT_EN_OFS, en_val);
    apb_write(ALERT_CLASS_OFS, cls_val);
    for (int c = 0; c < N_CLASSES; c++) begin
      for (int r = 0; r < 3; r++) begin
        exp_cfg[c][r] = $urandom & 32'hFFFF;
        apb_write(class_addr(c, cfg_ofs[r]), exp_cfg[c][r]);
      end
    end
    apb_read(ALERT_EN_OFS, data);
    check_data("ALERT_EN", data, en_val);
    check_data("pslverr on mapped read", 32'(last_slverr), 32'h0);
    apb_read(ALERT_CLASS_OFS, data);
    check_data("ALERT_CLASS", data, cls_val);
    for (int c = 0; c < N_CLASSES; c++) begin
      for (int r = 0; r < 3; r++) begin
        apb_read(class_addr(c, cfg_ofs[r]), data);
        check_data($sformatf("class %0d reg 0x%02h", c, cfg_ofs[r]), data, exp_cfg[c][r]);
      end
    end
    // Holes in the map inside a class block and past the last class
    apb_read(8'h18, data);
    check_data("pslverr at 0x18", 32'(last_slverr), 32'h1);
    check_data("rdata at 0x18", data, 32'h0);
    apb_write(class_addr(0, 8'h14), 32'hFFFF_FFFF);
    check_data("pslverr at 0x34", 32'(last_slverr), 32'h1);
    apb_write(class_addr(N_CLASSES, THRESH_OFS), 32'hFFFF_FFFF);
    check_data("pslverr past last class", 32'(last_slverr), 32'h1);
    // Neither bad write may alias onto a class threshold
    for (int c = 0; c < N_CLASSES; c++) begin
      apb_read(class_addr(c, THRESH_OFS), data);
      check_data($sformatf("class %0d THRESH after bad writes", c), data, exp_cfg[c][0]);
    end
    finish_test("registers");
  endtask

  task automatic test_classify();
    logic [31:0] data;
    start_test();
    // Alerts 0 to 3 enabled and only alert 3 mapped to class 1
    apb_write(ALERT_EN_OFS, 32'h0F);
    apb_write(ALERT_CLASS_OFS, 32'h08);
    apb_write(INTR_ENABLE_OFS, 32'h0);
    pulse_alert(8'h08);
    apb_read(ALERT_CAUSE_OFS, data);
    check_data("ALERT_CAUSE", data, 32'h08);
    apb_read(INTR_STATE_OFS, data);
    check_data("INTR_STATE", data, 32'h2);
    @(negedge clk);
    check_data("intr_o masked", 32'(intr), 32'h0);
    apb_write(INTR_ENABLE_OFS, 32'h2);
    @(negedge clk);
    check_data("intr_o enabled", 32'(intr), 32'h2);
    // Alert 5 is masked
    pulse_alert(8'h20);
    apb_read(ALERT_CAUSE_OFS, data);
    check_data("ALERT_CAUSE after masked", data, 32'h08);
    apb_read(INTR_STATE_OFS, data);
    check_data("INTR_STATE after masked", data, 32'h2);
    apb_write(INTR_STATE_OFS, 32'h2);
    apb_write(ALERT_CAUSE_OFS, 32'h08);
    apb_read(ALERT_CAUSE_OFS, data);
    check_data("ALERT_CAUSE cleared", data, 32'h0);
    apb_read(INTR_STATE_OFS, data);
    check_data("INTR_STATE cleared", data, 32'h0);
    @(negedge clk);
    check_data("intr_o cleared", 32'(intr), 32'h0);
    finish_test("classify");
  endtask

  task automatic test_accum();
    logic [31:0] data;
    start_test();
    apb_write(class_addr(0, THRESH_OFS), 32'd3);
    apb_write(class_addr(0, TIMEOUT_OFS), 32'd0);
    apb_write(class_addr(0, PHASE_OFS), 32'd8);
    apb_write(class_addr(0, CTRL_OFS), 32'h1);
    repeat (3) pulse_alert(8'h01);
    wait_esc(2'b01);
    check_esc("esc_o in phase 0", esc, 2'b01);
    wait_esc(2'b10);
    check_esc("esc_o in phase 1", esc, 2'b10);
    wait_state(0, ST_TERMINAL);
    apb_read(CLASS_STATE_OFS, data);
    check_state("class 0 state", esc_state_e'(data[2:0]), ST_TERMINAL);
    @(negedge clk);
    check_esc("esc_o in terminal", esc, 2'b10);
    apb_read(class_addr(0, ACCUM_CNT_OFS), data);
    check_data("class 0 ACCUM_CNT", data, 32'd3);
    finish_test("accumulation");
  endtask

  task automatic test_timeout();
    logic [31:0] data;
    start_test();
    apb_write(class_addr(1, THRESH_OFS), 32'hFFFF);
    apb_write(class_addr(1, TIMEOUT_OFS), 32'd40);
    apb_write(class_addr(1, PHASE_OFS), 32'd6);
    apb_write(class_addr(1, CTRL_OFS), 32'h1);
    // Interrupt serviced well before the timeout
    pulse_alert(8'h08);
    repeat (5) @(posedge clk);
    apb_write(INTR_STATE_OFS, 32'h2);
    repeat (60) @(posedge clk);
    apb_read(CLASS_STATE_OFS, data);
    check_state("class 1 state serviced", esc_state_e'(data[5:3]), ST_IDLE);
    // Interrupt left pending
    // Class 0 sits in terminal so esc_o bit 0 can only come from class 1
    pulse_alert(8'h08);
    wait_esc(2'b01);
    apb_read(CLASS_STATE_OFS, data);
    check_state("class 1 state on timeout", esc_state_e'(data[5:3]), ST_PHASE0);
    wait_state(1, ST_TERMINAL);
    finish_test("timeout");
  endtask

  task automatic test_clear_disable();
    logic [31:0] data;
    start_test();
    apb_write(INTR_STATE_OFS, 32'h3);
    apb_write(ALERT_CAUSE_OFS, 32'hFF);
    apb_write(class_addr(0, CTRL_OFS), 32'h3);
    apb_write(class_addr(1, CTRL_OFS), 32'h3);
    apb_read(CLASS_STATE_OFS, data);
    check_state("class 0 state after clear", esc_state_e'(data[2:0]), ST_IDLE);
    check_state("class 1 state after clear", esc_state_e'(data[5:3]), ST_IDLE);
    @(negedge clk);
    check_esc("esc_o after clear", esc, 2'b00);
    apb_read(class_addr(0, ACCUM_CNT_OFS), data);
    check_data("class 0 ACCUM_CNT after clear", data, 32'h0);
    apb_read(class_addr(1, ACCUM_CNT_OFS), data);
    check_data("class 1 ACCUM_CNT after clear", data, 32'h0);
    // More alerts than the threshold of 3 on a disabled class
    apb_write(class_addr(0, CTRL_OFS), 32'h0);
    repeat (5) pulse_alert(8'h01);
    apb_read(class_addr(0, ACCUM_CNT_OFS), data);
    check_data("class 0 ACCUM_CNT disabled", data, 32'h0);
    apb_read(CLASS_STATE_OFS, data);
    check_state("class 0 state disabled", esc_state_e'(data[2:0]), ST_IDLE);
    @(negedge clk);
    check_esc("esc_o disabled", esc, 2'b00);
    finish_test("clear_disable");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    n_checks       = 0;
    n_errors       = 0;
    n_tests        = 0;
    n_failed_tests = 0;
    err_base       = 0;
    last_slverr    = 1'b0;
    rst            = 1'b1;
    alert          = '0;
    apb_req        = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    test_registers();
    test_classify();
    test_accum();
    test_timeout();
    test_clear_disable();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hw/alert_pkg.sv
hw/alert_reg_apb.sv
hw/alert_classify.sv
hw/alert_accu.sv
hw/alert_irq_timeout.sv
hw/alert_esc_fsm.sv
hw/alert_handler_top.sv
sim/tb_alert_handler.sv

/* Makefile */
# Verilator build and run of the alert handler testbench

VERILATOR ?= verilator
TOP       ?= tb_alert_handler
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
